// File: sources.f
+incdir+.
sparcIsaPkg.sv
pipeCtrlPkg.sv
decodeIf.sv
instructionDecoder.sv
conditionUnit.sv
pcSequencer.sv
sparcFrontEnd.sv
tbSparcFrontEnd.sv

// File: run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbSparcFrontEnd \
    -Mdir obj_dir -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: tbSparcFrontEnd.sv
`timescale 1ns/1ps
`include "sparc_config.svh"

module tbSparcFrontEnd
    import sparcIsaPkg::*;
    import pipeCtrlPkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int MAX_GAP        = 3;      // Longest fetch stall between instructions
    localparam int TEST_INSTRS    = 300;    // Upper bound on issued instructions
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_INSTRS * (MAX_GAP + 1) + 100;
    localparam logic [`XLEN-1:0] NOP = '0;

    // Format 3 op3 codes and the ALU operation each one selects
    localparam logic [5:0] ARITH_OP3 [13] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05,
        6'h06, 6'h07, 6'h08, 6'h0C, 6'h25, 6'h26, 6'h27};
    localparam aluOpT ARITH_ALU [13] = '{ADD, AND, OR, XOR, SUB, ANDN, ORN, XNOR, ADDX,
        SUBX, SLL, SRL, SRA};
    // LD LDUB LDUH LDSB LDSH, then ST STB STH
    localparam logic [5:0] MEM_OP3 [8] = '{6'h00, 6'h01, 6'h02, 6'h09, 6'h0A, 6'h04,
        6'h05, 6'h06};
    localparam memSizeT MEM_SIZE [8] = '{WORD, BYTE, HALF, BYTE, HALF, WORD, BYTE, HALF};

    logic             Clk;
    logic             rstN;
    logic             fetchEn;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] jmplTarget;
    ccT               aluFlags;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    ctrlWordT         ctrlWord;
    ccT               condCodes;

    ctrlWordT expCtrl;      // Tabled decode of the word on instr
    int       errors;
    int       issued;
    bit       gapsOn;

    // Reference model state
    logic [`XLEN-1:0] mIfId, mPc, mNpc, mIdPc, mTarget, mNpcNext;
    ctrlWordT         mIfIdCtrl, mCtrl;
    ccT               mCC, mFlags;
    condT             mCond;
    nextPcSelT        mSel;
    logic             mBranch, mCall, mTaken, mFlush, flushPend;

    sparcFrontEnd dut (
        .Clk        (Clk),
        .rstN       (rstN),
        .fetchEn    (fetchEn),
        .instr      (instr),
        .jmplTarget (jmplTarget),
        .aluFlags   (aluFlags),
        .pc         (pc),
        .npc        (npc),
        .ctrlWord   (ctrlWord),
        .condCodes  (condCodes)
    );

    always #4 Clk = ~Clk;

    // SPARC integer condition table
    function automatic logic condTrue(input condT c, input ccT f);
        case (c)
            BN:      return 1'b0;
            BE:      return f.z;
            BLE:     return f.z || (f.n != f.v);
            BL:      return f.n != f.v;
            BLEU:    return f.c || f.z;
            BCS:     return f.c;
            BNEG:    return f.n;
            BVS:     return f.v;
            BA:      return 1'b1;
            BNE:     return !f.z;
            BG:      return !(f.z || (f.n != f.v));
            BGE:     return f.n == f.v;
            BGU:     return !(f.c || f.z);
            BCC:     return !f.c;
            BPOS:    return !f.n;
            default: return !f.v;     // BVC
        endcase
    endfunction

    always_comb
    begin
        mBranch = (mIfId[31:30] == 2'b00) && (mIfId[24:22] == 3'b010);
        mCall   = (mIfId[31:30] == 2'b01);
        mCond   = condT'(mIfId[28:25]);
        mFlags  = mCtrl.modifyCC ? aluFlags : mCC;
        mTaken  = mBranch && condTrue(mCond, mFlags);
        mFlush  = mBranch && mIfId[29] && (!mTaken || mCond == BA);
        if (mCall)
            mTarget = mIdPc + {mIfId[29:0], 2'b00};
        else
            mTarget = mIdPc + {{8{mIfId[21]}}, mIfId[21:0], 2'b00};
        if (mCtrl.jmpl)
            mSel = JMPL;
        else if (mCall)
            mSel = pipeCtrlPkg::CALL;
        else if (mTaken)
            mSel = BRANCH;
        else
            mSel = SEQ;
        case (mSel)
            JMPL:    mNpcNext = jmplTarget;
            SEQ:     mNpcNext = mNpc + `INSTR_BYTES;
            default: mNpcNext = mTarget;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            mIfId     <= '0;
            mIfIdCtrl <= '0;
            mCtrl     <= '0;
            mPc       <= `RESET_PC;
            mNpc      <= `RESET_PC + `INSTR_BYTES;
            mIdPc     <= `RESET_PC;
            mCC       <= '0;
            flushPend <= 1'b0;
        end
        else
        begin
            if (mCtrl.modifyCC)
                mCC <= aluFlags;
            flushPend <= fetchEn && mFlush;
            if (fetchEn)
            begin
                mIfId     <= mFlush ? NOP : instr;
                mIfIdCtrl <= mFlush ? '0 : expCtrl;
                mCtrl     <= mIfIdCtrl;
                mPc       <= mNpc;
                mNpc      <= mNpcNext;
                mIdPc     <= mPc;
            end
            else
                mCtrl <= '0;
        end
    end

    task automatic flagMismatch(input string what);
        errors++;
        $display("mismatch at %0t: %s", $time, what);
    endtask

    assert property (@(posedge Clk) $rose(rstN) |-> (pc == `RESET_PC)
        && (npc == `RESET_PC + `INSTR_BYTES) && (ctrlWord == '0) && (condCodes == '0))
        else flagMismatch("state right after reset");
    assert property (@(posedge Clk) disable iff (!rstN) fetchEn |=> (pc == $past(npc)))
        else flagMismatch("pc did not take previous npc");
    assert property (@(posedge Clk) disable iff (!rstN)
        !fetchEn |=> ($stable(pc) && $stable(npc) && (ctrlWord == '0)))
        else flagMismatch("stall did not hold pc/npc or left ctrlWord set");
    assert property (@(posedge Clk) disable iff (!rstN) pc == mPc)
        else flagMismatch($sformatf("pc %h, model %h", $sampled(pc), $sampled(mPc)));
    assert property (@(posedge Clk) disable iff (!rstN) npc == mNpc)
        else flagMismatch($sformatf("npc %h, model %h", $sampled(npc), $sampled(mNpc)));
    assert property (@(posedge Clk) disable iff (!rstN) ctrlWord == mCtrl)
        else flagMismatch($sformatf("ctrlWord %h, model %h", $sampled(ctrlWord),
            $sampled(mCtrl)));
    assert property (@(posedge Clk) disable iff (!rstN) condCodes == mCC)
        else flagMismatch($sformatf("condCodes %h, model %h", $sampled(condCodes),
            $sampled(mCC)));
    assert property (@(posedge Clk) disable iff (!rstN) flushPend |=> (ctrlWord == '0))
        else flagMismatch("annulled delay slot reached ctrlWord");
    assert property (@(posedge Clk) disable iff (!rstN)
        (mCtrl.jmpl && mTaken && fetchEn) |=> (npc == $past(jmplTarget)))
        else flagMismatch("taken branch beat JMPL in EX");

    function automatic logic [`XLEN-1:0] format3(input logic [1:0] op, input logic [5:0] op3);
        return {op, 5'($urandom), op3, 5'($urandom), 1'($urandom), 13'($urandom)};
    endfunction

    function automatic logic [`XLEN-1:0] branchWord(input logic a, input condT c);
        return {2'b00, a, c, 3'b010, 22'($urandom)};    // Bicc
    endfunction

    // Optional stall, then one instruction held for a single fetch edge
    task automatic issue(input logic [`XLEN-1:0] word, input ctrlWordT exp);
        int gap;
        gap = (gapsOn && ($urandom % 4 == 0)) ? int'($urandom_range(MAX_GAP, 1)) : 0;
        repeat (gap)
        begin
            @(posedge Clk);
            #1;
            fetchEn    = 1'b0;
            aluFlags   = 4'($urandom);
            jmplTarget = $urandom & 32'hFFFF_FFFC;
        end
        @(posedge Clk);
        #1;
        fetchEn    = 1'b1;
        instr      = word;
        expCtrl    = exp;
        aluFlags   = 4'($urandom);
        jmplTarget = $urandom & 32'hFFFF_FFFC;
        issued++;
    endtask

    task automatic runDecodeTable();
        ctrlWordT exp;
        for (int k = 0; k < 13; k++)
        begin
            exp          = '0;
            exp.aluOp    = ARITH_ALU[k];
            exp.rfEnable = 1'b1;
            issue(format3(2'b10, ARITH_OP3[k]), exp);
            if (k < 10)
            begin
                exp.modifyCC = 1'b1;                // cc variant
                issue(format3(2'b10, ARITH_OP3[k] | 6'h10), exp);
            end
        end
        for (int k = 0; k < 8; k++)
        begin
            exp           = '0;
            exp.memEnable = 1'b1;
            exp.aluOp     = ADD;
            exp.load      = (k < 5);
            exp.store     = (k >= 5);
            exp.rfEnable  = (k < 5);
            exp.signExt   = (k == 3) || (k == 4);
            exp.memSize   = MEM_SIZE[k];
            issue(format3(2'b11, MEM_OP3[k]), exp);
        end
        exp          = '0;
        exp.aluOp    = PASSB;
        exp.rfEnable = 1'b1;
        repeat (4)
            issue({2'b00, 5'($urandom), 3'b100, 22'($urandom)}, exp);   // SETHI
        issue(format3(2'b10, 6'h0B), '0);                              // Not in table
    endtask

    task automatic runBranches();
        ctrlWordT subcc;
        subcc          = '0;
        subcc.aluOp    = SUB;
        subcc.rfEnable = 1'b1;
        subcc.modifyCC = 1'b1;
        gapsOn = 1'b0;
        for (int k = 0; k < 16; k++)
        begin
            issue(format3(2'b10, 6'h14), subcc);       // Flags forwarded from EX
            issue(branchWord(1'b0, condT'(k[3:0])), '0);
            issue(NOP, '0);
            issue(format3(2'b10, 6'h14), subcc);       // Flags from the register
            issue(NOP, '0);
            issue(branchWord(1'b0, condT'(k[3:0])), '0);
            issue(NOP, '0);
        end
    endtask

    task automatic runCallJmpl();
        ctrlWordT callC;
        ctrlWordT jmplC;
        callC          = '0;
        callC.call     = 1'b1;
        callC.rfEnable = 1'b1;
        jmplC          = '0;
        jmplC.jmpl     = 1'b1;
        jmplC.aluOp    = ADD;
        jmplC.rfEnable = 1'b1;
        gapsOn = 1'b0;
        repeat (4)
        begin
            issue({2'b01, 30'($urandom)}, callC);
            issue(NOP, '0);
            issue(format3(2'b10, 6'h38), jmplC);
            issue(branchWord(1'b0, BA), '0);          // Taken while JMPL is in EX
            issue(NOP, '0);
            issue(NOP, '0);
        end
    endtask

    task automatic runAnnul();
        ctrlWordT add;
        add          = '0;
        add.aluOp    = ADD;
        add.rfEnable = 1'b1;
        gapsOn = 1'b0;
        repeat (4)
        begin
            issue(branchWord(1'b1, BN), '0);
            issue(format3(2'b10, 6'h00), add);
            issue(branchWord(1'b1, BA), '0);
            issue(format3(2'b10, 6'h00), add);
            issue(NOP, '0);
        end
        gapsOn = 1'b1;
        repeat (16)
        begin
            issue(branchWord(1'b1, condT'(4'($urandom))), '0);
            issue(format3(2'b10, 6'h00), add);
        end
    endtask

    initial
    begin
        void'($urandom(32'h84df_9b7d));
        Clk        = 1'b0;
        rstN       = 1'b0;
        fetchEn    = 1'b0;
        instr      = NOP;
        jmplTarget = '0;
        aluFlags   = '0;
        expCtrl    = '0;
        errors     = 0;
        issued     = 0;
        gapsOn     = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        rstN = 1'b1;
        repeat (40)
            issue(NOP, '0);       // Sequential fetch with random stalls
        runDecodeTable();
        runBranches();
        runCallJmpl();
        runAnnul();
        gapsOn = 1'b0;
        repeat (3)
            issue(NOP, '0);
        @(posedge Clk);
        #1;
        $display("%0d instructions issued, %0d errors", issued, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * 8);
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("%0d instructions issued, %0d errors", issued, errors);
        $display("tests failed");
        $finish;
    end

endmodule

// File: sparcFrontEnd.sv
`timescale 1ns/1ps
`include "sparc_config.svh"

module sparcFrontEnd
    import sparcIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic             Clk,
    input  logic             rstN,
    input  logic             fetchEn,      // Fetch advance, low stalls
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] jmplTarget,   // JMPL address from EX
    input  ccT               aluFlags,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] npc,
    output ctrlWordT         ctrlWord,
    output ccT               condCodes
);

    decodeIf decBus ();

    logic             taken;
    logic             flush;
    logic [`XLEN-1:0] idPc;

    instructionDecoder uDecoder (
        .Clk      (Clk),
        .rstN     (rstN),
        .fetchEn  (fetchEn),
        .instr    (instr),
        .flush    (flush),
        .idPc     (idPc),
        .dec      (decBus.producer),
        .ctrlWord (ctrlWord)
    );

    conditionUnit uCondition (
        .Clk        (Clk),
        .rstN       (rstN),
        .dec        (decBus.consumer),
        .exModifyCC (ctrlWord.modifyCC),
        .aluFlags   (aluFlags),
        .taken      (taken),
        .condCodes  (condCodes)
    );

    pcSequencer uSequencer (
        .Clk        (Clk),
        .rstN       (rstN),
        .fetchEn    (fetchEn),
        .dec        (decBus.consumer),
        .taken      (taken),
        .exJmpl     (ctrlWord.jmpl),
        .jmplTarget (jmplTarget),
        .pc         (pc),
        .npc        (npc),
        .idPc       (idPc),
        .flush      (flush)
    );

endmodule

// File: pcSequencer.sv
`timescale 1ns/1ps
`include "sparc_config.svh"

module pcSequencer
    import sparcIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic             Clk,
    input  logic             rstN,
    input  logic             fetchEn,
    decodeIf.consumer        dec,
    input  logic             taken,
    input  logic             exJmpl,
    input  logic [`XLEN-1:0] jmplTarget,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] npc,
    output logic [`XLEN-1:0] idPc,
    output logic             flush
);

    nextPcSelT        sel;
    logic [`XLEN-1:0] npcNext;

    // JMPL from EX is the oldest redirect and wins
    always_comb
    begin
        if (exJmpl)
            sel = JMPL;
        else if (dec.isCall && dec.idValid)
            sel = pipeCtrlPkg::CALL;
        else if (taken)
            sel = BRANCH;
        else
            sel = SEQ;
    end

    always_comb
    begin
        case (sel)
            JMPL:              npcNext = jmplTarget;
            pipeCtrlPkg::CALL: npcNext = dec.target;
            BRANCH:            npcNext = dec.target;
            default:           npcNext = npc + `INSTR_BYTES;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc   <= `RESET_PC;
            npc  <= `RESET_PC + `INSTR_BYTES;
            idPc <= `RESET_PC;
        end
        else if (fetchEn)
        begin
            pc   <= npc;
            npc  <= npcNext;
            idPc <= pc;      // PC of the word entering IF/ID
        end
    end

    // Squash the delay slot of an annulled branch
    assign flush = dec.isBranch && dec.idValid && dec.annul
                   && (!taken || dec.cond == BA);

    assert property (@(posedge Clk) disable iff (!rstN)
        (pc[1:0] == 2'b00) && (npc[1:0] == 2'b00))
        else $error("pc or npc not word aligned");

endmodule

// File: conditionUnit.sv
`timescale 1ns/1ps

module conditionUnit
    import sparcIsaPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    decodeIf.consumer dec,
    input  logic      exModifyCC,
    input  ccT        aluFlags,
    output logic      taken,
    output ccT        condCodes
);

    ccT storedCC;    // PSR icc field
    ccT evalCC;

    // Low three bits pick the test, bit 3 inverts it
    function automatic logic condMet(input condT c, input ccT f);
        logic base;
        case (condT'({1'b0, c[2:0]}))
            BN:      base = 1'b0;
            BE:      base = f.z;
            BLE:     base = f.z | (f.n ^ f.v);
            BL:      base = f.n ^ f.v;
            BLEU:    base = f.c | f.z;
            BCS:     base = f.c;
            BNEG:    base = f.n;
            BVS:     base = f.v;
            default: base = 1'b0;
        endcase
        return base ^ c[3];
    endfunction

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            storedCC <= '0;
        else if (exModifyCC)
            storedCC <= aluFlags;
    end

    // Forward flags of a CC-setting instruction still in EX
    assign evalCC = exModifyCC ? aluFlags : storedCC;

    assign taken     = dec.isBranch && dec.idValid && condMet(dec.cond, evalCC);
    assign condCodes = storedCC;

    // Only a valid branch in decode redirects fetch
    assert property (@(posedge Clk) disable iff (!rstN)
        taken |-> (dec.isBranch && dec.idValid))
        else $error("taken raised without a branch in decode");

endmodule

// File: instructionDecoder.sv
`timescale 1ns/1ps
`include "sparc_config.svh"

module instructionDecoder
    import sparcIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic             Clk,
    input  logic             rstN,
    input  logic             fetchEn,
    input  logic [`XLEN-1:0] instr,
    input  logic             flush,
    input  logic [`XLEN-1:0] idPc,
    decodeIf.producer        dec,
    output ctrlWordT         ctrlWord
);

    logic [`XLEN-1:0] ifId;          // IF/ID instruction register
    opT               op;
    logic [5:0]       op3;
    ctrlWordT         decoded;
    logic [`XLEN-1:0] dispCall;
    logic [`XLEN-1:0] dispBranch;

    assign op  = opT'(ifId[31:30]);
    assign op3 = ifId[24:19];

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            ifId <= '0;                      // Nop
        else if (fetchEn)
            ifId <= flush ? '0 : instr;      // Annulled delay slot dropped
    end

    // Word displacements scaled to bytes
    assign dispCall   = {ifId[29:0], 2'b00};
    assign dispBranch = {{(`XLEN-24){ifId[21]}}, ifId[21:0], 2'b00};

    assign dec.target  = idPc + ((op == sparcIsaPkg::CALL) ? dispCall : dispBranch);
    assign dec.idValid = (ifId != '0);

    always_comb
    begin
        decoded      = BUBBLE;
        dec.isBranch = 1'b0;
        dec.isCall   = 1'b0;
        dec.annul    = 1'b0;
        dec.cond     = condT'(ifId[28:25]);
        case (op)
            sparcIsaPkg::CALL:
            begin
                decoded.call     = 1'b1;
                decoded.rfEnable = 1'b1;      // Return address into r15
                dec.isCall       = 1'b1;
            end
            BRANCH_SETHI:
            begin
                if (ifId[24:22] == 3'b100)
                begin
                    decoded.aluOp    = PASSB; // SETHI loads imm22 through B
                    decoded.rfEnable = 1'b1;
                end
                else if (ifId != '0)
                begin
                    dec.isBranch = 1'b1;
                    dec.annul    = ifId[29];
                end
            end
            ARITH:
            begin
                decoded.rfEnable = 1'b1;
                if (op3 == 6'b111000)
                begin
                    decoded.jmpl  = 1'b1;     // Address is rs1 plus operand 2
                    decoded.aluOp = ADD;
                end
                else
                begin
                    decoded.modifyCC = ifId[23];
                    case (op3[3:0])
                        4'd0:    decoded.aluOp = ADD;
                        4'd8:    decoded.aluOp = ADDX;
                        4'd4:    decoded.aluOp = SUB;
                        4'd12:   decoded.aluOp = SUBX;
                        4'd1:    decoded.aluOp = AND;
                        4'd2:    decoded.aluOp = OR;
                        4'd3:    decoded.aluOp = XOR;
                        4'd5:    decoded.aluOp = op3[5] ? SLL : ANDN;
                        4'd6:    decoded.aluOp = op3[5] ? SRL : ORN;
                        4'd7:    decoded.aluOp = op3[5] ? SRA : XNOR;
                        default: decoded = BUBBLE;  // Unsupported op3
                    endcase
                end
            end
            MEM:
            begin
                case (op3)
                    6'b001001, 6'b001010, 6'b000000, 6'b000001, 6'b000010,
                    6'b000101, 6'b000110, 6'b000100:
                    begin
                        decoded.memEnable = 1'b1;
                        decoded.aluOp     = ADD;        // rs1 plus offset
                        decoded.store     = op3[2];
                        decoded.load      = !op3[2];
                        decoded.rfEnable  = !op3[2];    // Loads write rd
                        decoded.signExt   = op3[3];     // LDSB and LDSH only
                        case (op3[1:0])
                            2'b01:   decoded.memSize = BYTE;
                            2'b10:   decoded.memSize = HALF;
                            default: decoded.memSize = WORD;
                        endcase
                    end
                    default: decoded = BUBBLE;
                endcase
            end
            default: decoded = BUBBLE;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            ctrlWord <= BUBBLE;
        else if (fetchEn)
            ctrlWord <= decoded;
        else
            ctrlWord <= BUBBLE;    // Stall leaves EX empty
    end

    // A memory op in EX is either a load or a store, never both
    assert property (@(posedge Clk) disable iff (!rstN)
        !(ctrlWord.load && ctrlWord.store))
        else $error("ctrlWord carries load and store together");

endmodule

// File: decodeIf.sv
`timescale 1ns/1ps
`include "sparc_config.svh"

interface decodeIf
    import sparcIsaPkg::*;
();

    logic             isBranch;
    logic             isCall;
    logic             annul;      // Annul bit of a branch
    condT             cond;
    logic [`XLEN-1:0] target;     // Decode PC plus scaled displacement
    logic             idValid;    // IF/ID holds a real instruction

    modport producer (
        output isBranch, isCall, annul, cond, target, idValid
    );

    modport consumer (
        input isBranch, isCall, annul, cond, target, idValid
    );

endinterface

// File: pipeCtrlPkg.sv
package pipeCtrlPkg;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } memSizeT;

    // ID/EX payload, 14 bits, MSB first
    typedef struct packed {
        logic               jmpl;
        logic               store;
        sparcIsaPkg::aluOpT aluOp;
        logic               signExt;    // Sign extend loaded byte or half
        logic               load;
        logic               rfEnable;   // Destination register write
        memSizeT            memSize;
        logic               modifyCC;
        logic               call;
        logic               memEnable;
    } ctrlWordT;

    // All-zero control word, no side effects in later stages
    localparam ctrlWordT BUBBLE = '0;

    // Source of the next nPC value
    typedef enum logic [1:0] {
        SEQ,
        BRANCH,
        CALL,
        JMPL
    } nextPcSelT;

endpackage

// File: sparcIsaPkg.sv
package sparcIsaPkg;

    // Major opcode, instruction bits 31:30
    typedef enum logic [1:0] {
        BRANCH_SETHI = 2'd0,
        CALL         = 2'd1,
        ARITH        = 2'd2,
        MEM          = 2'd3
    } opT;

    // Same bit order as the ALU flag outputs
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } ccT;

    // Integer branch conditions; bit 3 negates the low half
    typedef enum logic [3:0] {
        BN   = 4'd0,
        BE   = 4'd1,
        BLE  = 4'd2,
        BL   = 4'd3,
        BLEU = 4'd4,
        BCS  = 4'd5,
        BNEG = 4'd6,
        BVS  = 4'd7,
        BA   = 4'd8,
        BNE  = 4'd9,
        BG   = 4'd10,
        BGE  = 4'd11,
        BGU  = 4'd12,
        BCC  = 4'd13,
        BPOS = 4'd14,
        BVC  = 4'd15
    } condT;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        ADDX  = 4'd1,
        SUB   = 4'd2,
        SUBX  = 4'd3,
        AND   = 4'd4,
        OR    = 4'd5,
        XOR   = 4'd6,
        XNOR  = 4'd7,
        ANDN  = 4'd8,
        ORN   = 4'd9,
        SLL   = 4'd10,
        SRL   = 4'd11,
        SRA   = 4'd12,
        PASSB = 4'd14    // Operand B straight through
    } aluOpT;

endpackage

// File: sparc_config.svh
`ifndef SPARC_CONFIG_SVH
`define SPARC_CONFIG_SVH

// Datapath word, also the width of every address and PC register
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Fixed instruction length, the sequential PC step
`define INSTR_BYTES 4

`endif
